/* bench/pulse_tx_tb.sv */
// Table-driven testbench for the pulse-train transmitter, compiled from sources.f with top pulse_tx_tb
module pulse_tx_tb;
    timeunit 1ns;
    timeprecision 100ps;

    // One stimulus row with its expectations
    typedef struct {
        string                      name;
        pulse_tx_pkg::ctrl_cfg_t    ctrl;
        pulse_tx_pkg::program_cfg_t prog;
        logic [31:0]                durations;
        logic [3:0]                 prescaler;
        int                         exp_symbols;
        logic                       exp_loop;
        logic                       stop_early;
    } test_row_t;

    logic        clk;
    logic        rst_n;
    logic [5:0]  address;
    logic [31:0] data_in;
    logic [1:0]  data_write_n;
    logic [31:0] data_out;
    logic        data_ready;
    logic        user_interrupt;
    logic        tx_out;
    logic        tx_valid;

    test_row_t   rows[4];
    // Copy of the program memory as written over the bus
    logic [31:0] tb_mem[8];
    // Expected and measured runs of equal output level
    logic        exp_level[$];
    int          exp_len[$];
    logic        got_level[$];
    int          got_len[$];
    logic        run_open;
    logic        run_level;
    int          run_count;
    int          checks;
    int          errors;
    int          timeouts;

    pulse_tx_top DUT (
        .clk            (clk),
        .rst_n          (rst_n),
        .address        (address),
        .data_in        (data_in),
        .data_write_n   (data_write_n),
        .data_out       (data_out),
        .data_ready     (data_ready),
        .user_interrupt (user_interrupt),
        .tx_out         (tx_out),
        .tx_valid       (tx_valid)
    );

    always #10 clk = ~clk;

    // Run monitor, samples mid-cycle while tx_valid is high
    always @(negedge clk) begin
        if (tx_valid === 1'b1 && run_open && tx_out === run_level) begin
            run_count++;
        end else begin
            if (run_open) begin
                got_level.push_back(run_level);
                got_len.push_back(run_count);
            end
            run_open = (tx_valid === 1'b1);
            run_level = tx_out;
            run_count = 1;
        end
    end

    // Fibonacci LFSR with taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    function automatic pulse_tx_pkg::ctrl_cfg_t make_ctrl(input logic [2:0] mask,
            input logic use_2bps, input logic idle, input logic invert, input logic [7:0] map);
        pulse_tx_pkg::ctrl_cfg_t c;
        c = '0;
        c.irq_mask = mask;
        c.use_2bps = use_2bps;
        c.idle_level = idle;
        c.invert_output = invert;
        // Map codes, high_odd in the top pair
        {c.high_odd, c.high_even, c.low_odd, c.low_even} = map;
        return c;
    endfunction

    function automatic pulse_tx_pkg::program_cfg_t make_prog(input int first, input int last,
            input int back, input int count);
        pulse_tx_pkg::program_cfg_t p;
        p.start_index = 8'(first);
        p.end_index = 8'(last);
        p.loopback_index = 8'(back);
        p.loop_count = 7'(count);
        return p;
    endfunction

    // Config fields sit above the command bits of the control word
    function automatic logic [31:0] ctrl_word(input pulse_tx_pkg::ctrl_cfg_t c);
        return 32'(c) << pulse_tx_pkg::CTRL_CFG_LSB;
    endfunction

    // Memory seen as one flat bit string
    function automatic logic mem_bit(input int n);
        return tb_mem[n / 32][n % 32];
    endfunction

    task automatic check_value(input string name, input string what, input int expected,
            input int actual);
        checks++;
        assert (expected == actual) else begin
            $display("FAILED %s %s: expected %0d, actual %0d", name, what, expected, actual);
            errors++;
        end
    endtask

    task automatic bus_write(input logic [5:0] addr, input logic [31:0] value,
            input logic [1:0] mode);
        @(posedge clk);
        address <= addr;
        data_in <= value;
        data_write_n <= mode;
        @(posedge clk);
        data_write_n <= 2'b11;
    endtask

    // Status is combinational, sampled mid-cycle
    task automatic read_status(output logic [31:0] value);
        @(negedge clk);
        assert (data_ready === 1'b1) else begin
            $display("data_ready was low during a status read");
            errors++;
        end
        value = data_out;
    endtask

    task automatic wait_valid(input logic want, input int limit, input string name);
        int n;
        n = 0;
        while (tx_valid !== want && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (tx_valid !== want) begin
            $display("Timeout in %s: tx_valid did not become %0b within %0d cycles",
                     name, want, limit);
            timeouts++;
        end
    endtask

    // Expected runs from the memory copy and the symbol rules
    task automatic build_expected(input test_row_t row, output int symbols);
        int pass;
        int pos;
        int cycles;
        logic [1:0] code;
        logic level;
        exp_level.delete();
        exp_len.delete();
        symbols = 0;
        for (pass = 0; pass <= row.prog.loop_count; pass++) begin
            pos = 2 * ((pass == 0) ? row.prog.start_index : row.prog.loopback_index);
            // Index k owns bits 2k+1:2k
            while (pos <= 2 * row.prog.end_index + 1) begin
                if (row.ctrl.use_2bps) begin
                    code = {mem_bit(pos + 1), mem_bit(pos)};
                    pos += 2;
                end else begin
                    if (mem_bit(pos)) begin
                        code = (pos % 2) ? row.ctrl.high_odd : row.ctrl.high_even;
                    end else begin
                        code = (pos % 2) ? row.ctrl.low_odd : row.ctrl.low_even;
                    end
                    pos += 1;
                end
                level = code[1] ^ row.ctrl.invert_output;
                cycles = (row.durations[8 * code +: 8] + 1) << row.prescaler;
                // Three cycle floor per symbol
                if (cycles < 3) begin
                    cycles = 3;
                end
                symbols++;
                // Equal neighbours merge into one visible run
                if (exp_level.size() > 0 && exp_level[$] == level) begin
                    exp_len[$] += cycles;
                end else begin
                    exp_level.push_back(level);
                    exp_len.push_back(cycles);
                end
            end
        end
    endtask

    task automatic compare_runs(input string name);
        int count;
        int i;
        check_value(name, "run count", exp_len.size(), got_len.size());
        count = (exp_len.size() < got_len.size()) ? exp_len.size() : got_len.size();
        for (i = 0; i < count; i++) begin
            check_value(name, $sformatf("run %0d level", i), exp_level[i], got_level[i]);
            check_value(name, $sformatf("run %0d length", i), exp_len[i], got_len[i]);
        end
    endtask

    task automatic run_test(input test_row_t row);
        logic [31:0] status;
        logic [31:0] base;
        logic [2:0]  exp_flags;
        logic        idle_out;
        int          symbols;
        int          limit;
        base = ctrl_word(row.ctrl);
        idle_out = row.ctrl.idle_level ^ row.ctrl.invert_output;
        // Config write also clears leftover flags
        bus_write(pulse_tx_pkg::ADDR_CTRL, base | 32'h7, 2'b10);
        bus_write(pulse_tx_pkg::ADDR_PROGRAM, 32'(row.prog), 2'b10);
        bus_write(pulse_tx_pkg::ADDR_DURATION, row.durations, 2'b10);
        bus_write(pulse_tx_pkg::ADDR_PRESCALE, 32'(row.prescaler), 2'b10);
        read_status(status);
        check_value(row.name, "idle symbol index", row.prog.start_index, status[23:16]);
        check_value(row.name, "idle loop counter", row.prog.loop_count, status[14:8]);
        check_value(row.name, "idle flags", 0, status[2:0]);
        check_value(row.name, "idle output", idle_out, tx_out);
        build_expected(row, symbols);
        check_value(row.name, "reference symbol count", row.exp_symbols, symbols);
        limit = 50;
        foreach (exp_len[i]) begin
            limit += exp_len[i];
        end
        got_level.delete();
        got_len.delete();
        bus_write(pulse_tx_pkg::ADDR_CTRL, base | (32'd1 << pulse_tx_pkg::START_BIT), 2'b10);
        wait_valid(1'b1, 20, row.name);
        if (row.stop_early) begin
            // A few symbols play first, setting the symbol flag
            repeat (20) @(posedge clk);
            bus_write(pulse_tx_pkg::ADDR_CTRL, base | (32'd1 << pulse_tx_pkg::STOP_BIT), 2'b10);
            wait_valid(1'b0, 10, row.name);
            read_status(status);
            check_value(row.name, "running after stop", 0, status[4]);
            check_value(row.name, "output after stop", idle_out, tx_out);
            check_value(row.name, "interrupt before clear", 1, user_interrupt);
            // Byte write of ones clears all flags
            bus_write(pulse_tx_pkg::ADDR_CTRL, 32'h7, 2'b00);
            read_status(status);
            check_value(row.name, "flags after clear", 0, status[2:0]);
            check_value(row.name, "interrupt after clear", 0, user_interrupt);
        end else begin
            wait_valid(1'b0, limit, row.name);
            // Monitor closes the last run on that edge
            @(posedge clk);
            compare_runs(row.name);
            read_status(status);
            exp_flags = {1'b1, row.exp_loop, 1'b1};
            check_value(row.name, "flags after end", exp_flags, status[2:0]);
            check_value(row.name, "running after end", 0, status[4]);
            check_value(row.name, "output after end", idle_out, tx_out);
            check_value(row.name, "interrupt after end", |(exp_flags & row.ctrl.irq_mask),
                        user_interrupt);
            // Mask of zero takes the line down with the flags still set
            bus_write(pulse_tx_pkg::ADDR_CTRL, base & ~(32'h7 << pulse_tx_pkg::CTRL_CFG_LSB),
                      2'b10);
            read_status(status);
            check_value(row.name, "interrupt when masked", 0, user_interrupt);
        end
    endtask

    initial begin : main
        logic [31:0] lfsr;
        int w;
        int b;
        int r;
        clk = 1'b0;
        rst_n = 1'b0;
        address = '0;
        data_in = '0;
        data_write_n = 2'b11;
        run_open = 1'b0;
        run_level = 1'b0;
        run_count = 0;
        checks = 0;
        errors = 0;
        timeouts = 0;
        // Program memory, one LFSR step per bit
        lfsr = 32'h1937b92d;
        for (w = 0; w < 8; w++) begin
            for (b = 0; b < 32; b++) begin
                lfsr = lfsr_step(lfsr);
                tb_mem[w][b] = lfsr[0];
            end
        end
        // Map order is high_odd, high_even, low_odd, low_even
        rows[0] = '{"bps2_durations", make_ctrl(3'b100, 1'b1, 1'b1, 1'b0, 8'h00),
                    make_prog(2, 9, 0, 0), 32'h03020100, 4'd1, 8, 1'b0, 1'b0};
        rows[1] = '{"bps1_inverted", make_ctrl(3'b100, 1'b0, 1'b0, 1'b1, 8'b01_11_10_00),
                    make_prog(5, 7, 0, 0), 32'h05010402, 4'd0, 6, 1'b0, 1'b0};
        rows[2] = '{"loop_twice", make_ctrl(3'b010, 1'b1, 1'b0, 1'b0, 8'h00),
                    make_prog(16, 19, 18, 2), 32'h06030502, 4'd0, 8, 1'b1, 1'b0};
        rows[3] = '{"stop_clear", make_ctrl(3'b001, 1'b1, 1'b0, 1'b0, 8'h00),
                    make_prog(0, 60, 0, 0), 32'h04040404, 4'd0, 61, 1'b0, 1'b1};
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        for (w = 0; w < 8; w++) begin
            bus_write({1'b1, 3'(w), 2'b00}, tb_mem[w], 2'b10);
        end
        for (r = 0; r < 4; r++) begin
            run_test(rows[r]);
        end
        $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* source/pulse_timer.sv */
// Plays each symbol for its prescaled duration and shapes the transmitted level
module pulse_timer (
    input  logic                    clk,
    input  logic                    rst_n,
    input  pulse_tx_pkg::ctrl_cfg_t ctrl,
    input  logic                    running,
    input  logic                    full,
    input  pulse_tx_pkg::symbol_t   symbol_in,
    input  logic                    last_in,
    output logic                    take,
    output logic                    tx_out,
    output logic                    tx_valid,
    output logic                    symbol_done,
    output logic                    program_end
);

    logic active;
    logic level_q;
    logic last_q;
    logic [pulse_tx_pkg::PRESCALE_WIDTH-1:0] presc_q;
    logic [pulse_tx_pkg::DIV_WIDTH-1:0] div_cnt;
    logic [pulse_tx_pkg::DIV_WIDTH-1:0] div_reload;
    logic [pulse_tx_pkg::DURATION_WIDTH-1:0] dur_cnt;
    // Cycles into the symbol, saturates at 2
    logic [1:0] age;
    logic expire;

    // 2^p - 1 as a mask of p ones
    assign div_reload = ~({pulse_tx_pkg::DIV_WIDTH{1'b1}} << presc_q);

    // Both counters drained and at least three cycles played
    assign expire = active && div_cnt == '0 && dur_cnt == '0 && age == 2'd2;
    assign take = running && full && (!active || expire);

    always_ff @(posedge clk) begin
        if (!rst_n || !running) begin
            active <= 1'b0;
            age <= 2'd0;
        end else if (take) begin
            active <= 1'b1;
            age <= 2'd0;
        end else if (expire) begin
            active <= 1'b0;
        end else if (active && age != 2'd2) begin
            age <= age + 2'd1;
        end
    end

    // Divider runs 2^p cycles per duration step
    always_ff @(posedge clk) begin
        if (take) begin
            level_q <= symbol_in.level;
            last_q <= last_in;
            presc_q <= symbol_in.prescaler;
            div_cnt <= ~({pulse_tx_pkg::DIV_WIDTH{1'b1}} << symbol_in.prescaler);
            dur_cnt <= symbol_in.duration;
        end else if (div_cnt != '0) begin
            div_cnt <= div_cnt - 1'b1;
        end else if (dur_cnt != '0) begin
            dur_cnt <= dur_cnt - 1'b1;
            div_cnt <= div_reload;
        end
    end

    assign symbol_done = expire;
    assign program_end = expire && last_q;
    assign tx_valid = active;

    // Idle level between programs, inversion applies to both
    assign tx_out = (active ? level_q : ctrl.idle_level) ^ ctrl.invert_output;

    // Refill latency keeps the next symbol ready before the current one ends
    assert property (@(posedge clk) disable iff (!rst_n)
        expire && !last_q && running |-> full);

endmodule

/* source/pulse_tx_pkg.sv */
// Shared sizes, register map and packed bundles for the pulse-train transmitter RTL
package pulse_tx_pkg;

    // Program memory geometry
    localparam int NUM_SYMBOL_WORDS = 8;
    localparam int WORD_SEL_WIDTH = $clog2(NUM_SYMBOL_WORDS);
    localparam int BIT_SEL_WIDTH = 5;

    // Index, position and counter widths
    localparam int INDEX_WIDTH = 8;
    localparam int PC_WIDTH = 9;
    localparam int LOOP_WIDTH = 7;
    localparam int DURATION_WIDTH = 8;
    localparam int PRESCALE_WIDTH = 4;
    // Widest prescale divider, 2^15 cycles minus one
    localparam int DIV_WIDTH = 2 ** PRESCALE_WIDTH - 1;
    localparam int NUM_IRQ = 3;
    localparam int CODE_WIDTH = 2;
    localparam int NUM_CODES = 2 ** CODE_WIDTH;

    // Bus word addresses
    localparam logic [5:0] ADDR_CTRL = 6'd0;
    localparam logic [5:0] ADDR_PROGRAM = 6'd4;
    localparam logic [5:0] ADDR_DURATION = 6'd8;
    localparam logic [5:0] ADDR_PRESCALE = 6'd12;
    localparam int MEM_BASE_BIT = 5;

    // Control word layout
    localparam int START_BIT = 4;
    localparam int STOP_BIT = 5;
    localparam int CTRL_CFG_LSB = 8;

    // Control word bits 22:8, MSB field first
    typedef struct packed {
        logic [CODE_WIDTH-1:0] high_odd;
        logic [CODE_WIDTH-1:0] high_even;
        logic [CODE_WIDTH-1:0] low_odd;
        logic [CODE_WIDTH-1:0] low_even;
        logic                  use_2bps;
        logic                  invert_output;
        logic                  idle_level;
        logic                  loop_forever;
        logic [NUM_IRQ-1:0]    irq_mask;
    } ctrl_cfg_t;

    // Program word, start index in the low byte
    typedef struct packed {
        logic [LOOP_WIDTH-1:0]  loop_count;
        logic [INDEX_WIDTH-1:0] loopback_index;
        logic [INDEX_WIDTH-1:0] end_index;
        logic [INDEX_WIDTH-1:0] start_index;
    } program_cfg_t;

    typedef struct packed {
        logic [NUM_CODES-1:0][DURATION_WIDTH-1:0] duration;
        logic [PRESCALE_WIDTH-1:0]                prescaler;
    } timing_cfg_t;

    typedef struct packed {
        logic                      level;
        logic [DURATION_WIDTH-1:0] duration;
        logic [PRESCALE_WIDTH-1:0] prescaler;
    } symbol_t;

    // Flag order matches status bits 2:0
    typedef struct packed {
        logic program_end;
        logic loop_wrap;
        logic symbol_done;
    } irq_events_t;

endpackage

/* source/pulse_tx_regs.sv */
// Register bank with program memory, run control and sticky interrupt flags on the bus
module pulse_tx_regs (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic [5:0]                             address,
    input  logic [31:0]                            data_in,
    input  logic [1:0]                             data_write_n,
    input  logic [pulse_tx_pkg::WORD_SEL_WIDTH-1:0] word_select,
    input  pulse_tx_pkg::irq_events_t              events,
    input  logic [pulse_tx_pkg::LOOP_WIDTH-1:0]    loop_count_now,
    input  logic [pulse_tx_pkg::INDEX_WIDTH-1:0]   symbol_index,
    output logic [31:0]                            data_out,
    output logic                                   data_ready,
    output pulse_tx_pkg::ctrl_cfg_t                ctrl,
    output pulse_tx_pkg::program_cfg_t             prog,
    output pulse_tx_pkg::timing_cfg_t              timing,
    output logic [31:0]                            program_word,
    output logic                                   running,
    output logic                                   start,
    output logic                                   user_interrupt
);

    logic [31:0] mem [pulse_tx_pkg::NUM_SYMBOL_WORDS];
    logic [pulse_tx_pkg::NUM_IRQ-1:0] flags;
    logic running_d;
    logic wr32;
    logic wr8;
    logic ctrl_hit;

    // 10 writes a full word and 00 only the status byte
    assign wr32 = data_write_n == 2'b10;
    assign wr8 = data_write_n == 2'b00;
    assign ctrl_hit = (wr32 || wr8) && address == pulse_tx_pkg::ADDR_CTRL;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ctrl <= '0;
            prog <= '0;
            timing <= '0;
            running <= 1'b0;
            running_d <= 1'b0;
            flags <= '0;
        end else begin
            running_d <= running;
            // Events stay sticky until software clears them
            flags <= flags | events;
            // Last symbol finished
            running <= running && !events.program_end;
            if (ctrl_hit) begin
                flags <= (flags & ~data_in[pulse_tx_pkg::NUM_IRQ-1:0]) | events;
                // Stop takes priority over start
                if (data_in[pulse_tx_pkg::STOP_BIT]) begin
                    running <= 1'b0;
                end else if (data_in[pulse_tx_pkg::START_BIT]) begin
                    running <= 1'b1;
                end
                if (wr32) begin
                    ctrl <= data_in[pulse_tx_pkg::CTRL_CFG_LSB +: $bits(pulse_tx_pkg::ctrl_cfg_t)];
                end
            end
            if (wr32 && address == pulse_tx_pkg::ADDR_PROGRAM) begin
                prog <= data_in[$bits(pulse_tx_pkg::program_cfg_t)-1:0];
            end
            if (wr32 && address == pulse_tx_pkg::ADDR_DURATION) begin
                timing.duration <= data_in;
            end
            if (wr32 && address == pulse_tx_pkg::ADDR_PRESCALE) begin
                timing.prescaler <= data_in[pulse_tx_pkg::PRESCALE_WIDTH-1:0];
            end
        end
    end

    // Program words live in the upper half of the map
    always_ff @(posedge clk) begin
        if (wr32 && address[pulse_tx_pkg::MEM_BASE_BIT]) begin
            mem[address[2 +: pulse_tx_pkg::WORD_SEL_WIDTH]] <= data_in;
        end
    end

    assign program_word = mem[word_select];

    // One cycle pulse on the first running cycle
    assign start = running && !running_d;

    // Only enabled flags reach the interrupt line
    assign user_interrupt = |(flags & ctrl.irq_mask);

    // Status word is returned whatever the read address
    assign data_out = {8'b0, symbol_index, 1'b0, loop_count_now, 3'b0, running, 1'b0, flags};
    assign data_ready = 1'b1;

    // Program end only arrives while a program runs
    assert property (@(posedge clk) disable iff (!rst_n)
        events.program_end |-> running);

endmodule

/* source/pulse_tx_top.sv */
// Top level joining the register bank, sequencer, prefetch and timer to the bus and pins
module pulse_tx_top (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [5:0]  address,
    input  logic [31:0] data_in,
    input  logic [1:0]  data_write_n,
    output logic [31:0] data_out,
    output logic        data_ready,
    output logic        user_interrupt,
    output logic        tx_out,
    output logic        tx_valid
);

    pulse_tx_pkg::ctrl_cfg_t ctrl;
    pulse_tx_pkg::program_cfg_t prog;
    pulse_tx_pkg::timing_cfg_t timing;
    pulse_tx_pkg::irq_events_t events;
    pulse_tx_pkg::symbol_t seq_symbol;
    pulse_tx_pkg::symbol_t pre_symbol;
    logic [pulse_tx_pkg::WORD_SEL_WIDTH-1:0] word_select;
    logic [pulse_tx_pkg::LOOP_WIDTH-1:0] loop_count_now;
    logic [pulse_tx_pkg::INDEX_WIDTH-1:0] symbol_index;
    logic [31:0] program_word;
    logic running;
    logic start;
    logic fill;
    logic seq_last;
    logic pre_last;
    logic full;
    logic refill;
    logic take;

    pulse_tx_regs u_regs (
        .clk            (clk),
        .rst_n          (rst_n),
        .address        (address),
        .data_in        (data_in),
        .data_write_n   (data_write_n),
        .word_select    (word_select),
        .events         (events),
        .loop_count_now (loop_count_now),
        .symbol_index   (symbol_index),
        .data_out       (data_out),
        .data_ready     (data_ready),
        .ctrl           (ctrl),
        .prog           (prog),
        .timing         (timing),
        .program_word   (program_word),
        .running        (running),
        .start          (start),
        .user_interrupt (user_interrupt)
    );

    symbol_sequencer u_sequencer (
        .clk            (clk),
        .rst_n          (rst_n),
        .ctrl           (ctrl),
        .prog           (prog),
        .timing         (timing),
        .running        (running),
        .start          (start),
        .refill         (refill),
        .program_word   (program_word),
        .word_select    (word_select),
        .symbol         (seq_symbol),
        .fill           (fill),
        .last           (seq_last),
        .loop_wrap      (events.loop_wrap),
        .loop_count_now (loop_count_now),
        .symbol_index   (symbol_index)
    );

    symbol_prefetch u_prefetch (
        .clk        (clk),
        .rst_n      (rst_n),
        .running    (running),
        .fill       (fill),
        .symbol_in  (seq_symbol),
        .last_in    (seq_last),
        .take       (take),
        .symbol_out (pre_symbol),
        .last_out   (pre_last),
        .full       (full),
        .refill     (refill)
    );

    pulse_timer u_timer (
        .clk         (clk),
        .rst_n       (rst_n),
        .ctrl        (ctrl),
        .running     (running),
        .full        (full),
        .symbol_in   (pre_symbol),
        .last_in     (pre_last),
        .take        (take),
        .tx_out      (tx_out),
        .tx_valid    (tx_valid),
        .symbol_done (events.symbol_done),
        .program_end (events.program_end)
    );

endmodule

/* source/symbol_prefetch.sv */
// One-entry register holding the next decoded symbol ready for the pulse timer
module symbol_prefetch (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  running,
    input  logic                  fill,
    input  pulse_tx_pkg::symbol_t symbol_in,
    input  logic                  last_in,
    input  logic                  take,
    output pulse_tx_pkg::symbol_t symbol_out,
    output logic                  last_out,
    output logic                  full,
    output logic                  refill
);

    always_ff @(posedge clk) begin
        if (!rst_n || !running) begin
            full <= 1'b0;
        end else if (fill) begin
            full <= 1'b1;
        end else if (take) begin
            full <= 1'b0;
        end
    end

    // Entry payload
    always_ff @(posedge clk) begin
        if (fill) begin
            symbol_out <= symbol_in;
            last_out <= last_in;
        end
    end

    // Nothing follows the last symbol
    assign refill = take && !last_out;

    // Sequencer only answers refills, so the entry is never overwritten
    assert property (@(posedge clk) disable iff (!rst_n)
        fill |-> !full || take);

endmodule

/* source/symbol_sequencer.sv */
// Walks the program positions, handles looping and decodes bits into timed symbols
module symbol_sequencer (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  pulse_tx_pkg::ctrl_cfg_t                ctrl,
    input  pulse_tx_pkg::program_cfg_t             prog,
    input  pulse_tx_pkg::timing_cfg_t              timing,
    input  logic                                   running,
    input  logic                                   start,
    input  logic                                   refill,
    input  logic [31:0]                            program_word,
    output logic [pulse_tx_pkg::WORD_SEL_WIDTH-1:0] word_select,
    output pulse_tx_pkg::symbol_t                  symbol,
    output logic                                   fill,
    output logic                                   last,
    output logic                                   loop_wrap,
    output logic [pulse_tx_pkg::LOOP_WIDTH-1:0]    loop_count_now,
    output logic [pulse_tx_pkg::INDEX_WIDTH-1:0]   symbol_index
);

    // Bit position whose upper eight bits are the index
    logic [pulse_tx_pkg::PC_WIDTH-1:0] pc;
    logic [pulse_tx_pkg::LOOP_WIDTH-1:0] loop_ctr;
    logic [pulse_tx_pkg::CODE_WIDTH-1:0] raw_pair;
    logic [pulse_tx_pkg::CODE_WIDTH-1:0] code;
    logic fill_q;
    logic at_end;
    logic wrap;

    assign word_select = pc[pulse_tx_pkg::BIT_SEL_WIDTH +: pulse_tx_pkg::WORD_SEL_WIDTH];
    assign raw_pair = program_word[{pc[pulse_tx_pkg::BIT_SEL_WIDTH-1:1], 1'b0} +: 2];

    // 2bps uses the pair as the code while 1bps maps one bit by value and parity
    always_comb begin
        if (ctrl.use_2bps) begin
            code = raw_pair;
        end else if (raw_pair[pc[0]]) begin
            code = pc[0] ? ctrl.high_odd : ctrl.high_even;
        end else begin
            code = pc[0] ? ctrl.low_odd : ctrl.low_even;
        end
    end

    assign symbol.level = code[1];
    assign symbol.duration = timing.duration[code];
    assign symbol.prescaler = timing.prescaler;

    // In 1bps both bits of the end index are played
    assign at_end = pc[pulse_tx_pkg::PC_WIDTH-1:1] == prog.end_index
                    && pc[0] == !ctrl.use_2bps;
    assign last = at_end && !ctrl.loop_forever && loop_ctr == '0;
    assign wrap = at_end && !last;
    // A stop drops running before a pending fill can reach the prefetch
    assign fill = fill_q && running;
    assign loop_wrap = fill && wrap;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= '0;
            loop_ctr <= '0;
            fill_q <= 1'b0;
        end else if (!running || start) begin
            // Idle tracks the configuration so status shows it
            pc <= {prog.start_index, 1'b0};
            loop_ctr <= prog.loop_count;
            fill_q <= start;
        end else begin
            fill_q <= refill;
            if (fill && wrap) begin
                pc <= {prog.loopback_index, 1'b0};
                if (!ctrl.loop_forever) begin
                    loop_ctr <= loop_ctr - 1'b1;
                end
            end else if (fill && !last) begin
                pc <= pc + (ctrl.use_2bps ? 9'd2 : 9'd1);
            end
        end
    end

    assign loop_count_now = loop_ctr;
    assign symbol_index = pc[pulse_tx_pkg::PC_WIDTH-1:1];

    // Refills come only mid-run and never with the start pulse
    assert property (@(posedge clk) disable iff (!rst_n)
        refill |-> running && !start);

endmodule

/* sources.f */
source/pulse_tx_pkg.sv
source/pulse_tx_regs.sv
source/symbol_sequencer.sv
source/symbol_prefetch.sv
source/pulse_timer.sv
source/pulse_tx_top.sv
bench/pulse_tx_tb.sv
